// ==== hw/pipeCtrl_defines.svh ====
`ifndef PIPECTRL_DEFINES_SVH
`define PIPECTRL_DEFINES_SVH

// register number width, fixed by the instruction format
`define REG_ADDR_W 5

// hard-wired zero register
`define REG_ZERO {`REG_ADDR_W{1'b0}}

`endif

// ==== hw/pipeCtrlPkg.sv ====
package pipeCtrlPkg;

	// instruction class as seen by the hazard logic
	typedef enum logic [1:0] {
		cmdOther = 2'b00,
		cmdJump  = 2'b01,
		cmdStore = 2'b10,
		cmdLoad  = 2'b11
	} cmdType;

	// bypass source for an E operand
	typedef enum logic [1:0] {
		fwdReg = 2'b00,
		fwdMem = 2'b01,
		fwdWb  = 2'b10
	} fwdSel;

	// data-cache access sequencing
	typedef enum logic {
		accIdle = 1'b0,
		accWait = 1'b1
	} accessState;

endpackage

// ==== hw/stageTagIf.sv ====
`timescale 1ns/100ps
`include "pipeCtrl_defines.svh"

interface stageTagIf import pipeCtrlPkg::*; ();

	// per-stage class, sources, destination and write enable
	cmdType dCmd, eCmd, mCmd, wCmd;
	logic [`REG_ADDR_W-1:0] dRs1, dRs2, dRd;
	logic [`REG_ADDR_W-1:0] eRs1, eRs2, eRd;
	logic [`REG_ADDR_W-1:0] mRs1, mRs2, mRd;
	logic [`REG_ADDR_W-1:0] wRs1, wRs2, wRd;
	logic dWe, eWe, mWe, wWe;

	modport driver (
		output dCmd, dRs1, dRs2, dRd, dWe,
		output eCmd, eRs1, eRs2, eRd, eWe,
		output mCmd, mRs1, mRs2, mRd, mWe,
		output wCmd, wRs1, wRs2, wRd, wWe
	);

	modport reader (
		input dCmd, dRs1, dRs2, dRd, dWe,
		input eCmd, eRs1, eRs2, eRd, eWe,
		input mCmd, mRs1, mRs2, mRd, mWe,
		input wCmd, wRs1, wRs2, wRd, wWe
	);

endinterface

// ==== hw/stageTagPipe.sv ====
`timescale 1ns/100ps
`include "pipeCtrl_defines.svh"

module stageTagPipe import pipeCtrlPkg::*; (
	input logic clk,
	input logic reset,
	input cmdType decCmd,
	input logic [`REG_ADDR_W-1:0] decRs1,
	input logic [`REG_ADDR_W-1:0] decRs2,
	input logic [`REG_ADDR_W-1:0] decRd,
	input logic decWe,
	input logic freeze,
	input logic holdFront,
	input logic bubble,
	input logic flushD,
	input logic flushE,
	stageTagIf.driver tags
);

	// E gets a cleared tag on a bubble or a flush
	logic clearE;

	assign clearE = bubble || flushE;

	////////////////////////////////////////////////////////////
	// tag registers
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			tags.dCmd <= cmdOther;
			tags.dRs1 <= '0;
			tags.dRs2 <= '0;
			tags.dRd  <= '0;
			tags.dWe  <= 1'b0;
			tags.eCmd <= cmdOther;
			tags.eRs1 <= '0;
			tags.eRs2 <= '0;
			tags.eRd  <= '0;
			tags.eWe  <= 1'b0;
			tags.mCmd <= cmdOther;
			tags.mRs1 <= '0;
			tags.mRs2 <= '0;
			tags.mRd  <= '0;
			tags.mWe  <= 1'b0;
			tags.wCmd <= cmdOther;
			tags.wRs1 <= '0;
			tags.wRs2 <= '0;
			tags.wRd  <= '0;
			tags.wWe  <= 1'b0;
		end else if (!freeze) begin
			// back end always advances when not frozen
			tags.wCmd <= tags.mCmd;
			tags.wRs1 <= tags.mRs1;
			tags.wRs2 <= tags.mRs2;
			tags.wRd  <= tags.mRd;
			tags.wWe  <= tags.mWe;
			tags.mCmd <= tags.eCmd;
			tags.mRs1 <= tags.eRs1;
			tags.mRs2 <= tags.eRs2;
			tags.mRd  <= tags.eRd;
			tags.mWe  <= tags.eWe;

			if (clearE) begin
				tags.eCmd <= cmdOther;
				tags.eRs1 <= '0;
				tags.eRs2 <= '0;
				tags.eRd  <= '0;
				tags.eWe  <= 1'b0;
			end else begin
				tags.eCmd <= tags.dCmd;
				tags.eRs1 <= tags.dRs1;
				tags.eRs2 <= tags.dRs2;
				tags.eRd  <= tags.dRd;
				tags.eWe  <= tags.dWe;
			end

			// flush beats hold, hold keeps D as it is
			if (flushD) begin
				tags.dCmd <= cmdOther;
				tags.dRs1 <= '0;
				tags.dRs2 <= '0;
				tags.dRd  <= '0;
				tags.dWe  <= 1'b0;
			end else if (!holdFront) begin
				tags.dCmd <= decCmd;
				tags.dRs1 <= decRs1;
				tags.dRs2 <= decRs2;
				tags.dRd  <= decRd;
				tags.dWe  <= decWe;
			end
		end
	end

	// only a jump may carry a write enable towards r0
	function automatic logic badZeroWrite(cmdType cmd, logic we,
		logic [`REG_ADDR_W-1:0] rd);
		return we && (rd == `REG_ZERO) && (cmd != cmdJump);
	endfunction

	zeroWriteOnlyJump: assert property (@(posedge clk) disable iff (reset)
		!(badZeroWrite(tags.dCmd, tags.dWe, tags.dRd) ||
		  badZeroWrite(tags.eCmd, tags.eWe, tags.eRd) ||
		  badZeroWrite(tags.mCmd, tags.mWe, tags.mRd) ||
		  badZeroWrite(tags.wCmd, tags.wWe, tags.wRd)))
		else $error("stageTagPipe: non-jump tag writes the zero register");

endmodule

// ==== hw/dataAccessFsm.sv ====
`timescale 1ns/100ps

module dataAccessFsm import pipeCtrlPkg::*; (
	input logic clk,
	input logic reset,
	stageTagIf.reader tags,
	input logic dAck,
	output logic dReq,
	output logic memBusy
);

	accessState state;
	accessState stateNext;
	logic memInM;

	assign memInM = (tags.mCmd == cmdLoad) || (tags.mCmd == cmdStore);

	////////////////////////////////////////////////////////////
	// request sequencing
	////////////////////////////////////////////////////////////

	always_comb begin
		stateNext = state;
		dReq = 1'b0;
		memBusy = 1'b0;
		unique case (state)
			accIdle: begin
				// ack is not looked at here
				if (memInM) begin
					dReq = 1'b1;
					memBusy = 1'b1;
					stateNext = accWait;
				end
			end
			accWait: begin
				// release M in the ack cycle itself
				if (dAck) begin
					stateNext = accIdle;
				end else begin
					memBusy = 1'b1;
				end
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= accIdle;
		end else begin
			state <= stateNext;
		end
	end

	reqOnlyFromIdle: assert property (@(posedge clk) disable iff (reset)
		dReq |-> state == accIdle)
		else $error("dataAccessFsm: dReq outside accIdle");

	// the freeze during issue keeps the same M tag from issuing twice in a row
	noBackToBackReq: assert property (@(posedge clk) disable iff (reset)
		dReq |=> !dReq)
		else $error("dataAccessFsm: adjacent dReq pulses");

endmodule

// ==== hw/forwardUnit.sv ====
`timescale 1ns/100ps
`include "pipeCtrl_defines.svh"

module forwardUnit import pipeCtrlPkg::*; (
	stageTagIf.reader tags,
	output fwdSel fwdA,
	output fwdSel fwdB,
	output logic fwdStore
);

	// M wins over W, r0 never bypasses
	function automatic fwdSel pickSrc(logic [`REG_ADDR_W-1:0] rs);
		fwdSel sel;
		sel = fwdReg;
		if (rs != `REG_ZERO) begin
			if (tags.mWe && (rs == tags.mRd)) begin
				sel = fwdMem;
			end else if (tags.wWe && (rs == tags.wRd)) begin
				sel = fwdWb;
			end
		end
		return sel;
	endfunction

	////////////////////////////////////////////////////////////
	// operand and store-data bypass
	////////////////////////////////////////////////////////////

	always_comb begin
		fwdA = pickSrc(tags.eRs1);
		fwdB = pickSrc(tags.eRs2);
	end

	// load result in W feeding the store data still sitting in M
	assign fwdStore = (tags.mCmd == cmdStore) && (tags.wCmd == cmdLoad) &&
		(tags.wRd != `REG_ZERO) && (tags.wRd == tags.mRs2);

	always_comb begin
		zeroSrcFromReg: assert (
			((tags.eRs1 != `REG_ZERO) || (fwdA == fwdReg)) &&
			((tags.eRs2 != `REG_ZERO) || (fwdB == fwdReg)))
			else $error("forwardUnit: r0 operand takes a bypass path");
	end

endmodule

// ==== hw/stallFlushUnit.sv ====
`timescale 1ns/100ps
`include "pipeCtrl_defines.svh"

module stallFlushUnit import pipeCtrlPkg::*; (
	stageTagIf.reader tags,
	input logic iReady,
	input logic memBusy,
	input logic mispredict,
	output logic freeze,
	output logic holdFront,
	output logic bubble,
	output logic flushD,
	output logic flushE
);

	logic loadUse;
	logic jumpWait;
	logic hazard;

	////////////////////////////////////////////////////////////
	// hazard detection
	////////////////////////////////////////////////////////////

	// load result not ready for the instruction behind it
	always_comb begin
		loadUse = (tags.eCmd == cmdLoad) && (tags.eRd != `REG_ZERO) &&
			((tags.eRd == tags.dRs1) || (tags.eRd == tags.dRs2));
	end

	// jump in D waits out a pending register write in W
	always_comb begin
		jumpWait = (tags.dCmd == cmdJump) && tags.wWe && (tags.wRd != `REG_ZERO);
	end

	assign hazard = loadUse || jumpWait;

	////////////////////////////////////////////////////////////
	// control outputs
	////////////////////////////////////////////////////////////

	// either side not ready stops every stage
	assign freeze = !iReady || memBusy;

	always_comb begin
		flushD = 1'b0;
		flushE = 1'b0;
		holdFront = 1'b0;
		bubble = 1'b0;
		if (!freeze) begin
			if (mispredict) begin
				// wrong-path work in D and E is dropped
				flushD = 1'b1;
				flushE = 1'b1;
			end else if (hazard) begin
				holdFront = 1'b1;
				bubble = 1'b1;
			end
		end
	end

	always_comb begin
		flushNotFrozen: assert (!(flushD && freeze))
			else $error("stallFlushUnit: flush while pipeline frozen");
	end

endmodule

// ==== hw/pipeCtrlTop.sv ====
`timescale 1ns/100ps
`include "pipeCtrl_defines.svh"

module pipeCtrlTop import pipeCtrlPkg::*; (
	input logic clk,
	input logic reset,
	input cmdType decCmd,
	input logic [`REG_ADDR_W-1:0] decRs1,
	input logic [`REG_ADDR_W-1:0] decRs2,
	input logic [`REG_ADDR_W-1:0] decRd,
	input logic decWe,
	input logic iReady,
	input logic mispredict,
	input logic dAck,
	output fwdSel fwdA,
	output fwdSel fwdB,
	output logic fwdStore,
	output logic dReq,
	output logic freeze,
	output logic holdFront,
	output logic bubble,
	output logic flushD,
	output logic flushE,
	output cmdType memCmd,
	output logic [`REG_ADDR_W-1:0] wbRd,
	output logic wbWe
);

	logic memBusy;

	stageTagIf u_tags ();

	stageTagPipe u_stageTagPipe (
		.clk(clk),
		.reset(reset),
		.decCmd(decCmd),
		.decRs1(decRs1),
		.decRs2(decRs2),
		.decRd(decRd),
		.decWe(decWe),
		.freeze(freeze),
		.holdFront(holdFront),
		.bubble(bubble),
		.flushD(flushD),
		.flushE(flushE),
		.tags(u_tags.driver)
	);

	dataAccessFsm u_dataAccessFsm (
		.clk(clk),
		.reset(reset),
		.tags(u_tags.reader),
		.dAck(dAck),
		.dReq(dReq),
		.memBusy(memBusy)
	);

	forwardUnit u_forwardUnit (
		.tags(u_tags.reader),
		.fwdA(fwdA),
		.fwdB(fwdB),
		.fwdStore(fwdStore)
	);

	stallFlushUnit u_stallFlushUnit (
		.tags(u_tags.reader),
		.iReady(iReady),
		.memBusy(memBusy),
		.mispredict(mispredict),
		.freeze(freeze),
		.holdFront(holdFront),
		.bubble(bubble),
		.flushD(flushD),
		.flushE(flushE)
	);

	// M class and W write controls for the datapath
	assign memCmd = u_tags.mCmd;
	assign wbRd = u_tags.wRd;
	assign wbWe = u_tags.wWe;

endmodule

// ==== verif/pipeCtrlTb.sv ====
`timescale 1ns/100ps
`include "pipeCtrl_defines.svh"

module pipeCtrlTb import pipeCtrlPkg::*; ();

	localparam int RESET_CYCLES = 10;
	localparam int RANDOM_CYCLES = 2000;
	// directed part and drain, well rounded up
	localparam int DIRECTED_BUDGET = 490;
	localparam int CYCLE_LIMIT = RESET_CYCLES + DIRECTED_BUDGET + RANDOM_CYCLES;

	typedef struct packed {
		cmdType cmd;
		logic [`REG_ADDR_W-1:0] rs1;
		logic [`REG_ADDR_W-1:0] rs2;
		logic [`REG_ADDR_W-1:0] rd;
		logic we;
	} tagT;

	localparam tagT CLEAR_TAG = '{cmdOther, 5'd0, 5'd0, 5'd0, 1'b0};

	logic clk;
	logic reset;
	cmdType decCmd;
	logic [`REG_ADDR_W-1:0] decRs1;
	logic [`REG_ADDR_W-1:0] decRs2;
	logic [`REG_ADDR_W-1:0] decRd;
	logic decWe;
	logic iReady;
	logic mispredict;
	logic dAck;
	fwdSel fwdA;
	fwdSel fwdB;
	logic fwdStore;
	logic dReq;
	logic freeze;
	logic holdFront;
	logic bubble;
	logic flushD;
	logic flushE;
	cmdType memCmd;
	logic [`REG_ADDR_W-1:0] wbRd;
	logic wbWe;

	// reference model state
	tagT tagD, tagE, tagM, tagW;
	accessState accModel;
	logic loadUseHaz, jumpHaz;
	logic expReq, expBusy, expFreeze, expHold, expFlush, expFwdStore;
	fwdSel expFwdA, expFwdB;
	int cycleCount = 0;

	// D and E tags inside the DUT
	tagT dutD, dutE;

	pipeCtrlTop u_pipeCtrlTop (
		.clk(clk), .reset(reset),
		.decCmd(decCmd), .decRs1(decRs1), .decRs2(decRs2), .decRd(decRd), .decWe(decWe),
		.iReady(iReady), .mispredict(mispredict), .dAck(dAck),
		.fwdA(fwdA), .fwdB(fwdB), .fwdStore(fwdStore), .dReq(dReq),
		.freeze(freeze), .holdFront(holdFront), .bubble(bubble),
		.flushD(flushD), .flushE(flushE),
		.memCmd(memCmd), .wbRd(wbRd), .wbWe(wbWe)
	);

	assign dutD = {u_pipeCtrlTop.u_tags.dCmd, u_pipeCtrlTop.u_tags.dRs1,
		u_pipeCtrlTop.u_tags.dRs2, u_pipeCtrlTop.u_tags.dRd, u_pipeCtrlTop.u_tags.dWe};
	assign dutE = {u_pipeCtrlTop.u_tags.eCmd, u_pipeCtrlTop.u_tags.eRs1,
		u_pipeCtrlTop.u_tags.eRs2, u_pipeCtrlTop.u_tags.eRd, u_pipeCtrlTop.u_tags.eWe};

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic failRun(input string what);
		$display("%s", what);
		$display("=== FAIL ===");
		$fatal(1, "stopped at first failure");
	endtask

	task automatic reportMismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		failRun($sformatf("Error: %s is 0x%0h, expected 0x%0h", name, got, exp));
	endtask

	// M before W, r0 always from the register file
	function automatic fwdSel bypassFor(logic [`REG_ADDR_W-1:0] rs, tagT m, tagT w);
		if (rs == `REG_ZERO) begin
			return fwdReg;
		end else if (m.we && m.rd == rs) begin
			return fwdMem;
		end else if (w.we && w.rd == rs) begin
			return fwdWb;
		end
		return fwdReg;
	endfunction

	////////////////////////////////////////////////////////////
	// reference model
	////////////////////////////////////////////////////////////

	always_comb begin
		loadUseHaz = (tagE.cmd == cmdLoad) && (tagE.rd != `REG_ZERO) &&
			(tagE.rd == tagD.rs1 || tagE.rd == tagD.rs2);
		jumpHaz = (tagD.cmd == cmdJump) && tagW.we && (tagW.rd != `REG_ZERO);
		expReq = (accModel == accIdle) && (tagM.cmd == cmdLoad || tagM.cmd == cmdStore);
		expBusy = expReq || (accModel == accWait && !dAck);
		expFreeze = !iReady || expBusy;
		expFlush = !expFreeze && mispredict;
		expHold = !expFreeze && !mispredict && (loadUseHaz || jumpHaz);
		expFwdA = bypassFor(tagE.rs1, tagM, tagW);
		expFwdB = bypassFor(tagE.rs2, tagM, tagW);
		expFwdStore = (tagM.cmd == cmdStore) && (tagW.cmd == cmdLoad) &&
			(tagW.rd != `REG_ZERO) && (tagW.rd == tagM.rs2);
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			tagD <= CLEAR_TAG;
			tagE <= CLEAR_TAG;
			tagM <= CLEAR_TAG;
			tagW <= CLEAR_TAG;
			accModel <= accIdle;
		end else begin
			if (expReq) begin
				accModel <= accWait;
			end else if (accModel == accWait && dAck) begin
				accModel <= accIdle;
			end
			if (!freeze) begin
				tagW <= tagM;
				tagM <= tagE;
				tagE <= (bubble || flushE) ? CLEAR_TAG : tagD;
				if (flushD) begin
					tagD <= CLEAR_TAG;
				end else if (!holdFront) begin
					tagD <= '{decCmd, decRs1, decRs2, decRd, decWe};
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= CYCLE_LIMIT) begin
			failRun("timeout: the run went past its cycle limit");
		end
	end

	////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////

	chkFreeze: assert property (@(posedge clk) disable iff (reset) freeze == expFreeze)
		else reportMismatch("freeze", 32'($sampled(freeze)), 32'($sampled(expFreeze)));
	chkHold: assert property (@(posedge clk) disable iff (reset) holdFront == expHold)
		else reportMismatch("holdFront", 32'($sampled(holdFront)), 32'($sampled(expHold)));
	chkBubble: assert property (@(posedge clk) disable iff (reset) bubble == expHold)
		else reportMismatch("bubble", 32'($sampled(bubble)), 32'($sampled(expHold)));
	chkFlushD: assert property (@(posedge clk) disable iff (reset) flushD == expFlush)
		else reportMismatch("flushD", 32'($sampled(flushD)), 32'($sampled(expFlush)));
	chkFlushE: assert property (@(posedge clk) disable iff (reset) flushE == expFlush)
		else reportMismatch("flushE", 32'($sampled(flushE)), 32'($sampled(expFlush)));
	chkReq: assert property (@(posedge clk) disable iff (reset) dReq == expReq)
		else reportMismatch("dReq", 32'($sampled(dReq)), 32'($sampled(expReq)));
	chkFwdA: assert property (@(posedge clk) disable iff (reset) fwdA == expFwdA)
		else reportMismatch("fwdA", 32'($sampled(fwdA)), 32'($sampled(expFwdA)));
	chkFwdB: assert property (@(posedge clk) disable iff (reset) fwdB == expFwdB)
		else reportMismatch("fwdB", 32'($sampled(fwdB)), 32'($sampled(expFwdB)));
	chkFwdStore: assert property (@(posedge clk) disable iff (reset) fwdStore == expFwdStore)
		else reportMismatch("fwdStore", 32'($sampled(fwdStore)), 32'($sampled(expFwdStore)));
	chkMemCmd: assert property (@(posedge clk) disable iff (reset) memCmd == tagM.cmd)
		else reportMismatch("memCmd", 32'($sampled(memCmd)), 32'($sampled(tagM.cmd)));
	chkWbRd: assert property (@(posedge clk) disable iff (reset) wbRd == tagW.rd)
		else reportMismatch("wbRd", 32'($sampled(wbRd)), 32'($sampled(tagW.rd)));
	chkWbWe: assert property (@(posedge clk) disable iff (reset) wbWe == tagW.we)
		else reportMismatch("wbWe", 32'($sampled(wbWe)), 32'($sampled(tagW.we)));

	// instruction side stall alone
	notReadyOnlyFreezes: assert property (@(posedge clk) disable iff (reset)
		!iReady |-> freeze && !holdFront && !bubble && !flushD && !flushE)
		else failRun("iReady low raised a control output other than freeze");
	reqOnePulse: assert property (@(posedge clk) disable iff (reset) dReq |=> !dReq)
		else failRun("dReq stayed high for more than one cycle");
	frozenNoMove: assert property (@(posedge clk) disable iff (reset)
		freeze |=> $stable(memCmd) && $stable(wbRd) && $stable(wbWe))
		else failRun("M or W outputs moved across a frozen edge");
	holdKeepsD: assert property (@(posedge clk) disable iff (reset)
		holdFront |=> dutE == CLEAR_TAG && dutD == $past(tagD))
		else failRun("a hold did not bubble E and keep D");

	////////////////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////////////////

	task automatic sendInstr(input cmdType cmd, input logic [`REG_ADDR_W-1:0] rs1,
		input logic [`REG_ADDR_W-1:0] rs2, input logic [`REG_ADDR_W-1:0] rd, input logic we);
		@(posedge clk);
		decCmd <= cmd;
		decRs1 <= rs1;
		decRs2 <= rs2;
		decRd <= rd;
		decWe <= we;
		// keep it on the inputs until D can take it
		do begin
			@(negedge clk);
		end while (freeze || holdFront);
	endtask

	task automatic ackAfter(input int waitCycles);
		do begin
			@(negedge clk);
		end while (!dReq);
		repeat (waitCycles) @(posedge clk);
		dAck <= 1'b1;
		@(posedge clk);
		dAck <= 1'b0;
	endtask

	task automatic driveRandom();
		cmdType cmd;
		logic [`REG_ADDR_W-1:0] rd;
		logic we;
		cmd = cmdType'(2'($urandom_range(0, 3)));
		rd = 5'($urandom_range(0, 3));
		we = ($urandom_range(0, 1) == 1);
		// stores never write, only jumps may name r0 with a write
		if (cmd == cmdStore || (cmd != cmdJump && rd == `REG_ZERO)) begin
			we = 1'b0;
		end
		decCmd <= cmd;
		decRs1 <= 5'($urandom_range(0, 3));
		decRs2 <= 5'($urandom_range(0, 3));
		decRd <= rd;
		decWe <= we;
		iReady <= ($urandom_range(0, 3) != 0);
		dAck <= ($urandom_range(0, 3) != 0);
		mispredict <= ($urandom_range(0, 7) == 0);
	endtask

	initial begin
		void'($urandom(32'hce512eef));
		reset = 1'b1;
		decCmd = cmdOther;
		decRs1 = '0;
		decRs2 = '0;
		decRd = '0;
		decWe = 1'b0;
		iReady = 1'b1;
		mispredict = 1'b0;
		dAck = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;

		// bypass from M over W, W alone, then r0 source
		sendInstr(cmdOther, 5'd0, 5'd0, 5'd1, 1'b1);
		sendInstr(cmdOther, 5'd0, 5'd0, 5'd1, 1'b1);
		sendInstr(cmdOther, 5'd1, 5'd2, 5'd2, 1'b1);
		sendInstr(cmdOther, 5'd0, 5'd0, 5'd3, 1'b1);
		sendInstr(cmdOther, 5'd0, 5'd0, 5'd0, 1'b0);
		sendInstr(cmdOther, 5'd3, 5'd3, 5'd0, 1'b0);
		sendInstr(cmdJump, 5'd0, 5'd0, 5'd0, 1'b1);
		sendInstr(cmdOther, 5'd0, 5'd0, 5'd0, 1'b0);

		// load-use on the next instruction
		sendInstr(cmdLoad, 5'd2, 5'd0, 5'd3, 1'b1);
		sendInstr(cmdOther, 5'd3, 5'd0, 5'd4, 1'b1);
		sendInstr(cmdOther, 5'd0, 5'd0, 5'd0, 1'b0);

		// load then store of its result with a slow cache
		@(posedge clk);
		dAck <= 1'b0;
		fork
			begin
				sendInstr(cmdLoad, 5'd1, 5'd0, 5'd5, 1'b1);
				sendInstr(cmdStore, 5'd1, 5'd5, 5'd0, 1'b0);
				sendInstr(cmdOther, 5'd0, 5'd0, 5'd0, 1'b0);
			end
			begin
				ackAfter(3);
				ackAfter(2);
			end
		join
		@(posedge clk);
		dAck <= 1'b1;

		// instruction side not ready
		@(posedge clk);
		iReady <= 1'b0;
		repeat (3) @(posedge clk);
		iReady <= 1'b1;

		// misprediction drops two writers
		sendInstr(cmdOther, 5'd0, 5'd0, 5'd6, 1'b1);
		sendInstr(cmdOther, 5'd0, 5'd0, 5'd7, 1'b1);
		@(posedge clk);
		decCmd <= cmdOther;
		decRd <= '0;
		decWe <= 1'b0;
		mispredict <= 1'b1;
		@(posedge clk);
		mispredict <= 1'b0;

		// jump waits for the write in W
		sendInstr(cmdOther, 5'd0, 5'd0, 5'd4, 1'b1);
		sendInstr(cmdOther, 5'd0, 5'd0, 5'd0, 1'b0);
		sendInstr(cmdOther, 5'd0, 5'd0, 5'd0, 1'b0);
		sendInstr(cmdJump, 5'd0, 5'd0, 5'd0, 1'b0);
		sendInstr(cmdOther, 5'd0, 5'd0, 5'd0, 1'b0);

		repeat (RANDOM_CYCLES) begin
			@(posedge clk);
			driveRandom();
		end
		@(posedge clk);
		iReady <= 1'b1;
		dAck <= 1'b1;
		mispredict <= 1'b0;
		repeat (5) @(posedge clk);
		$display("=== PASS ===");
		$finish;
	end

endmodule

// ==== build.f ====
+incdir+hw
hw/pipeCtrlPkg.sv
hw/stageTagIf.sv
hw/stageTagPipe.sv
hw/dataAccessFsm.sv
hw/forwardUnit.sv
hw/stallFlushUnit.sv
hw/pipeCtrlTop.sv
verif/pipeCtrlTb.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = pipeCtrlTb
FILELIST = build.f
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)

run: build
	./$(OBJDIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "=== PASS ===" $(LOG)

lint:
	$(SIM) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)
